// File: source/ctlb_pkg.sv
package ctlb_pkg;

  // Address split of a 4 KB page virtual address on a 64-bit core
  localparam int VPN_BITS  = 52;
  localparam int SET_BITS  = 6;
  localparam int TAG_BITS  = VPN_BITS - SET_BITS;
  localparam int ASID_BITS = 16;
  localparam int PPN_BITS  = 29;

  localparam int NUM_WAYS = 4;
  localparam int NUM_SETS = 1 << SET_BITS;

  typedef logic [VPN_BITS-1:0]  vpn_t;
  typedef logic [SET_BITS-1:0]  set_idx_t;
  typedef logic [TAG_BITS-1:0]  tag_t;
  typedef logic [ASID_BITS-1:0] asid_t;
  typedef logic [PPN_BITS-1:0]  ppn_t;
  typedef logic [1:0]           age_t; // 0 is newest, 3 is the victim

  typedef logic [15:0] csr_addr_t;
  typedef logic [63:0] csr_data_t;

  // Translation word returned on a hit
  typedef struct packed {
    ppn_t ppn;
    logic global;
    logic user;
    logic exec;
  } ctlb_data_t;

  typedef struct packed {
    logic       valid;
    asid_t      asid;
    tag_t       tag;
    ctlb_data_t data;
    age_t       age;
  } ctlb_entry_t;

  localparam csr_addr_t CSR_PROC   = 16'h0010; // Process id in the low 16 bits
  localparam csr_addr_t CSR_MFLAGS = 16'h0011;

  localparam int MFLAGS_VM = 5;

endpackage

// File: source/ctlb_ram.sv
`timescale 1ns/100ps

module ctlb_ram (
  input  logic                  clk,
  input  ctlb_pkg::set_idx_t    addr,
  output ctlb_pkg::ctlb_entry_t rdata,
  input  logic                  we,
  input  ctlb_pkg::ctlb_entry_t wdata
);

  ctlb_pkg::ctlb_entry_t mem [ctlb_pkg::NUM_SETS];

  // Same address for read and write, so a write-back sees the entry it modifies
  assign rdata = mem[addr];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[addr] <= wdata;
  end

endmodule

// File: source/ctlb_way.sv
`timescale 1ns/100ps

module ctlb_way #(
  parameter int WAY_NO = 0
) (
  input  logic                  clk,
  input  ctlb_pkg::set_idx_t    set,
  input  ctlb_pkg::tag_t        tag,
  input  ctlb_pkg::asid_t       cur_asid,
  input  logic                  init,
  input  logic                  refill_we,
  input  logic                  inval_we,
  input  logic                  age_we,
  input  ctlb_pkg::age_t        new_age,
  input  ctlb_pkg::ctlb_data_t  refill_data,
  output logic                  hit,
  output ctlb_pkg::ctlb_entry_t entry,
  output ctlb_pkg::age_t        age
);

  ctlb_pkg::ctlb_entry_t wdata;
  logic                  we;
  logic                  tag_eq;
  logic                  space_ok;

  ctlb_ram ram0 (
    .clk   (clk),
    .addr  (set),
    .rdata (entry),
    .we    (we),
    .wdata (wdata)
  );

  assign tag_eq   = entry.tag == tag;
  assign space_ok = (entry.asid == cur_asid) || entry.data.global; // Global pages ignore ASID
  assign hit      = entry.valid && tag_eq && space_ok;
  assign age      = entry.age;

  assign we = init | refill_we | inval_we | age_we;

  // Write-back entry, init first, then refill, invalidate and age update
  always_comb
  begin
    wdata = entry;
    if (init)
    begin
      wdata     = '0;
      wdata.age = ctlb_pkg::age_t'(WAY_NO); // Way k starts with age k
    end
    else if (refill_we)
    begin
      wdata.valid = 1'b1;
      wdata.asid  = cur_asid;
      wdata.tag   = tag;
      wdata.data  = refill_data;
      wdata.age   = '0;
    end
    else if (inval_we)
    begin
      wdata.valid = 1'b0; // Age is left alone
    end
    else
    begin
      wdata.age = new_age;
    end
  end

endmodule

// File: source/ctlb_lru_update.sv
`timescale 1ns/100ps

module ctlb_lru_update (
  input  logic                                    clk,
  input  ctlb_pkg::age_t [ctlb_pkg::NUM_WAYS-1:0] ages,
  input  logic [ctlb_pkg::NUM_WAYS-1:0]           sel,
  input  logic                                    apply,
  output ctlb_pkg::age_t [ctlb_pkg::NUM_WAYS-1:0] new_ages
);

  ctlb_pkg::age_t                sel_age;
  logic [ctlb_pkg::NUM_WAYS-1:0] age_seen;

  // Sel is one-hot, so OR picks out the age of the selected way
  always_comb
  begin
    sel_age = '0;
    for (int i = 0; i < ctlb_pkg::NUM_WAYS; i++)
    begin
      if (sel[i])
        sel_age = sel_age | ages[i];
    end
  end

  always_comb
  begin
    for (int i = 0; i < ctlb_pkg::NUM_WAYS; i++)
    begin
      new_ages[i] = ages[i];
      if (apply && sel[i])
        new_ages[i] = '0;
      else if (apply && (ages[i] < sel_age))
        new_ages[i] = ages[i] + 1'b1; // Younger than the selected way
    end
  end

  always_comb
  begin
    age_seen = '0;
    for (int i = 0; i < ctlb_pkg::NUM_WAYS; i++)
      age_seen[ages[i]] = 1'b1;
  end

  // The ways of a set must always hold a permutation of 0 to 3
  a_age_perm: assert property (@(posedge clk) apply |-> (&age_seen))
    else $error("ctlb ages of the set are not a permutation: %p", ages);

endmodule

// File: source/ctlb_csr_watch.sv
`timescale 1ns/100ps

module ctlb_csr_watch (
  input  logic                clk,
  input  logic                rst,
  input  logic                csr_en,
  input  ctlb_pkg::csr_addr_t csr_addr,
  input  ctlb_pkg::csr_data_t csr_data,
  output ctlb_pkg::asid_t     cur_asid
);

  ctlb_pkg::asid_t proc_id;
  logic            vm_en;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      proc_id <= '0;
      vm_en   <= 1'b0;
    end
    else if (csr_en)
    begin
      if (csr_addr == ctlb_pkg::CSR_PROC)
        proc_id <= csr_data[ctlb_pkg::ASID_BITS-1:0];
      if (csr_addr == ctlb_pkg::CSR_MFLAGS)
        vm_en <= csr_data[ctlb_pkg::MFLAGS_VM]; // Only the VM bit matters here
    end
  end

  // With VM off everything runs in address space zero
  assign cur_asid = vm_en ? proc_id : '0;

endmodule

// File: source/ctlb.sv
`timescale 1ns/100ps

module ctlb (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lookup_en,
  input  ctlb_pkg::vpn_t       vpn,
  input  logic                 stall,
  input  logic                 refill,
  input  ctlb_pkg::ctlb_data_t refill_data,
  input  logic                 invalidate,
  input  logic                 csr_en,
  input  ctlb_pkg::csr_addr_t  csr_addr,
  input  ctlb_pkg::csr_data_t  csr_data,
  output logic                 read_hit,
  output ctlb_pkg::ctlb_data_t read_data,
  output logic                 init_busy
);

  localparam int NW = ctlb_pkg::NUM_WAYS;

  ctlb_pkg::set_idx_t                init_cnt;
  ctlb_pkg::set_idx_t                set;
  ctlb_pkg::tag_t                    tag;
  ctlb_pkg::asid_t                   cur_asid;
  ctlb_pkg::ctlb_entry_t [NW-1:0]    way_entry;
  ctlb_pkg::age_t [NW-1:0]           way_age;
  ctlb_pkg::age_t [NW-1:0]           new_age;
  logic [NW-1:0]                     hit_way;
  logic [NW-1:0]                     victim;
  logic [NW-1:0]                     target;
  logic [NW-1:0]                     lru_sel;
  logic                              any_hit;
  logic                              active;
  logic                              do_refill;
  logic                              do_inval;
  logic                              do_lookup;
  logic                              lru_apply;

  // Init sweep clears one set per cycle and does not wait for stall
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_busy <= 1'b1;
      init_cnt  <= '0;
    end
    else if (init_busy)
    begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == ctlb_pkg::set_idx_t'(ctlb_pkg::NUM_SETS - 1))
        init_busy <= 1'b0;
    end
  end

  assign set = init_busy ? init_cnt : vpn[ctlb_pkg::SET_BITS-1:0];
  assign tag = vpn[ctlb_pkg::VPN_BITS-1:ctlb_pkg::SET_BITS];

  ctlb_csr_watch csr0 (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .cur_asid (cur_asid)
  );

  assign any_hit  = |hit_way;
  assign read_hit = any_hit & ~init_busy;

  always_comb
  begin
    read_data = '0;
    for (int k = 0; k < NW; k++)
    begin
      if (hit_way[k] && !init_busy)
        read_data = read_data | way_entry[k].data;
    end
  end

  always_comb
  begin
    for (int k = 0; k < NW; k++)
      victim[k] = way_age[k] == 2'd3;
  end

  // A refill of a vpn already present overwrites it in place
  assign target = any_hit ? hit_way : victim;

  assign active    = ~init_busy & ~stall;
  assign do_refill = active & refill;
  assign do_inval  = active & ~refill & invalidate & any_hit;
  assign do_lookup = active & ~refill & ~invalidate & lookup_en & any_hit;

  assign lru_apply = do_refill | do_lookup;
  assign lru_sel   = do_refill ? target : hit_way;

  ctlb_lru_update lru0 (
    .clk      (clk),
    .ages     (way_age),
    .sel      (lru_sel),
    .apply    (lru_apply),
    .new_ages (new_age)
  );

  for (genvar k = 0; k < NW; k++)
  begin : g_way
    ctlb_way #(
      .WAY_NO (k)
    ) way0 (
      .clk         (clk),
      .set         (set),
      .tag         (tag),
      .cur_asid    (cur_asid),
      .init        (init_busy),
      .refill_we   (do_refill & target[k]),
      .inval_we    (do_inval & hit_way[k]),
      .age_we      (lru_apply),
      .new_age     (new_age[k]),
      .refill_data (refill_data),
      .hit         (hit_way[k]),
      .entry       (way_entry[k]),
      .age         (way_age[k])
    );
  end

  // Refill reuses the hitting way, so an address never lands in two ways of a set
  a_hit_onehot: assert property (@(posedge clk) disable iff (rst || init_busy)
    (lookup_en || refill || invalidate) |-> $onehot0(hit_way))
    else $error("ctlb multiple ways hit: %b", hit_way);

endmodule

// File: test/ctlb_tb.sv
`timescale 1ns/100ps

module ctlb_tb;

  logic                  clk;
  logic                  rst;
  logic                  lookup_en;
  ctlb_pkg::vpn_t        vpn;
  logic                  stall;
  logic                  refill;
  ctlb_pkg::ctlb_data_t  refill_data;
  logic                  invalidate;
  logic                  csr_en;
  ctlb_pkg::csr_addr_t   csr_addr;
  ctlb_pkg::csr_data_t   csr_data;
  logic                  read_hit;
  ctlb_pkg::ctlb_data_t  read_data;
  logic                  init_busy;

  // Shadow copy of the TLB arrays and the ASID registers
  logic                 m_valid [ctlb_pkg::NUM_WAYS][ctlb_pkg::NUM_SETS];
  ctlb_pkg::asid_t      m_asid  [ctlb_pkg::NUM_WAYS][ctlb_pkg::NUM_SETS];
  ctlb_pkg::tag_t       m_tag   [ctlb_pkg::NUM_WAYS][ctlb_pkg::NUM_SETS];
  ctlb_pkg::ctlb_data_t m_data  [ctlb_pkg::NUM_WAYS][ctlb_pkg::NUM_SETS];
  ctlb_pkg::age_t       m_age   [ctlb_pkg::NUM_WAYS][ctlb_pkg::NUM_SETS];
  ctlb_pkg::asid_t      m_proc;
  logic                 m_vm;
  logic                 m_init_busy;
  int                   m_init_cnt;

  int n_checks = 0;
  int n_hits = 0;
  int err_hit = 0;
  int err_data = 0;
  int err_other = 0;

  ctlb dut0 (
    .clk         (clk),
    .rst         (rst),
    .lookup_en   (lookup_en),
    .vpn         (vpn),
    .stall       (stall),
    .refill      (refill),
    .refill_data (refill_data),
    .invalidate  (invalidate),
    .csr_en      (csr_en),
    .csr_addr    (csr_addr),
    .csr_data    (csr_data),
    .read_hit    (read_hit),
    .read_data   (read_data),
    .init_busy   (init_busy)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Expected hit and translation for a vpn under the model's current ASID
  function automatic logic ctlb_expect(input ctlb_pkg::vpn_t v, output ctlb_pkg::ctlb_data_t d,
                                       output int way);
    int              s;
    ctlb_pkg::tag_t  t;
    ctlb_pkg::asid_t cur;
    logic            hit;
    s = int'(v[ctlb_pkg::SET_BITS-1:0]);
    t = v[ctlb_pkg::VPN_BITS-1:ctlb_pkg::SET_BITS];
    cur = m_vm ? m_proc : '0;
    hit = 1'b0;
    d = '0;
    way = 0;
    if (m_init_busy)
      return 1'b0; // Nothing hits while the sweep runs
    for (int k = 0; k < ctlb_pkg::NUM_WAYS; k++)
    begin
      if (m_valid[k][s] && m_tag[k][s] == t && (m_asid[k][s] == cur || m_data[k][s].global))
      begin
        hit = 1'b1;
        d = m_data[k][s];
        way = k;
      end
    end
    return hit;
  endfunction

  function automatic int oldest_way(input int s);
    int w;
    w = 0;
    for (int k = 0; k < ctlb_pkg::NUM_WAYS; k++)
      if (m_age[k][s] == 2'd3)
        w = k;
    return w;
  endfunction

  // Touched way becomes newest, every way that was younger gets one older
  task automatic age_touch(input int s, input int w);
    ctlb_pkg::age_t a;
    a = m_age[w][s];
    for (int k = 0; k < ctlb_pkg::NUM_WAYS; k++)
    begin
      if (k == w)
        m_age[k][s] = '0;
      else if (m_age[k][s] < a)
        m_age[k][s] = m_age[k][s] + 1'b1;
    end
  endtask

  task automatic model_reset();
    for (int k = 0; k < ctlb_pkg::NUM_WAYS; k++)
    begin
      for (int s = 0; s < ctlb_pkg::NUM_SETS; s++)
      begin
        m_valid[k][s] = 1'b0;
        m_asid[k][s] = '0;
        m_tag[k][s] = '0;
        m_data[k][s] = '0;
        m_age[k][s] = ctlb_pkg::age_t'(k);
      end
    end
    m_proc = '0;
    m_vm = 1'b0;
    m_init_busy = 1'b1;
    m_init_cnt = 0;
  endtask

  // Applies what the coming clock edge does to the model
  task automatic model_step();
    logic                 hit;
    ctlb_pkg::ctlb_data_t d;
    int                   w;
    int                   tgt;
    int                   s;
    hit = ctlb_expect(vpn, d, w);
    s = int'(vpn[ctlb_pkg::SET_BITS-1:0]);
    if (m_init_busy)
    begin
      if (m_init_cnt == ctlb_pkg::NUM_SETS - 1)
        m_init_busy = 1'b0;
      m_init_cnt++;
    end
    else if (!stall)
    begin
      if (refill)
      begin
        tgt = hit ? w : oldest_way(s);
        age_touch(s, tgt);
        m_valid[tgt][s] = 1'b1;
        m_asid[tgt][s] = m_vm ? m_proc : '0;
        m_tag[tgt][s] = vpn[ctlb_pkg::VPN_BITS-1:ctlb_pkg::SET_BITS];
        m_data[tgt][s] = refill_data;
      end
      else if (invalidate)
      begin
        if (hit)
          m_valid[w][s] = 1'b0;
      end
      else if (lookup_en && hit)
        age_touch(s, w);
    end
    if (csr_en && csr_addr == ctlb_pkg::CSR_PROC)
      m_proc = csr_data[ctlb_pkg::ASID_BITS-1:0];
    if (csr_en && csr_addr == ctlb_pkg::CSR_MFLAGS)
      m_vm = csr_data[ctlb_pkg::MFLAGS_VM];
  endtask

  task automatic check_outputs();
    logic                 hit;
    ctlb_pkg::ctlb_data_t d;
    int                   w;
    hit = ctlb_expect(vpn, d, w);
    n_checks++;
    if (hit)
      n_hits++;
    if (init_busy !== m_init_busy)
    begin
      err_other++;
      $display("Error at %0t: init_busy is %b, expected %b", $time, init_busy, m_init_busy);
    end
    if (read_hit !== hit)
    begin
      err_hit++;
      $display("Error at %0t: read_hit is %b, expected %b for vpn %h", $time, read_hit, hit, vpn);
    end
    if (read_data !== d)
    begin
      err_data++;
      $display("Error at %0t: read_data is %h, expected %h for vpn %h", $time, read_data, d, vpn);
    end
  endtask

  // Outputs are settled 1 ns before each rising edge
  always @(posedge clk)
  begin
    #9;
    if (rst)
      model_reset();
    else
    begin
      check_outputs();
      model_step();
    end
  end

  function automatic ctlb_pkg::ctlb_data_t rand_data(input logic global_pg);
    ctlb_pkg::ctlb_data_t d;
    d.ppn = ctlb_pkg::ppn_t'($urandom);
    d.global = global_pg;
    d.user = 1'($urandom % 2);
    d.exec = 1'($urandom % 2);
    return d;
  endfunction

  function automatic ctlb_pkg::vpn_t random_vpn();
    return ctlb_pkg::vpn_t'({$urandom, $urandom});
  endfunction

  task automatic drive_op(input logic lk, input logic rf, input logic inv, input logic st,
                          input ctlb_pkg::vpn_t v, input ctlb_pkg::ctlb_data_t d);
    @(posedge clk);
    #1;
    lookup_en = lk;
    refill = rf;
    invalidate = inv;
    stall = st;
    vpn = v;
    refill_data = d;
    csr_en = 1'b0;
  endtask

  task automatic lookup(input ctlb_pkg::vpn_t v);
    drive_op(1'b1, 1'b0, 1'b0, 1'b0, v, '0);
  endtask

  task automatic refill_entry(input ctlb_pkg::vpn_t v, input ctlb_pkg::ctlb_data_t d);
    drive_op(1'b0, 1'b1, 1'b0, 1'b0, v, d);
  endtask

  task automatic invalidate_entry(input ctlb_pkg::vpn_t v);
    drive_op(1'b0, 1'b0, 1'b1, 1'b0, v, '0);
  endtask

  task automatic csr_write(input ctlb_pkg::csr_addr_t a, input ctlb_pkg::csr_data_t d);
    @(posedge clk);
    #1;
    lookup_en = 1'b0;
    refill = 1'b0;
    invalidate = 1'b0;
    stall = 1'b0;
    csr_en = 1'b1;
    csr_addr = a;
    csr_data = d;
  endtask

  initial
  begin
    int                 n;
    ctlb_pkg::vpn_t     va;
    ctlb_pkg::vpn_t     vg;
    ctlb_pkg::set_idx_t s;
    ctlb_pkg::vpn_t     pool [5];
    void'($urandom(32'h6952));
    rst = 1'b1;
    lookup_en = 1'b0;
    vpn = '0;
    stall = 1'b0;
    refill = 1'b0;
    refill_data = '0;
    invalidate = 1'b0;
    csr_en = 1'b0;
    csr_addr = '0;
    csr_data = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Random requests during the sweep must all be ignored
    n = 0;
    while (init_busy === 1'b1 && n < 200)
    begin
      @(posedge clk);
      #1;
      n++;
      vpn = random_vpn();
      lookup_en = 1'b1;
      refill = init_busy ? 1'($urandom % 2) : 1'b0;
      refill_data = rand_data(1'b0);
    end
    if (init_busy !== 1'b0)
    begin
      $display("Timeout: init_busy did not fall within 200 cycles after reset");
      $display("Something failed");
      $finish;
    end
    if (n != ctlb_pkg::NUM_SETS)
    begin
      err_other++;
      $display("Error at %0t: init_busy was high for %0d cycles, expected 64", $time, n);
    end
    for (int i = 0; i < ctlb_pkg::NUM_SETS; i++)
      lookup({ctlb_pkg::tag_t'($urandom), ctlb_pkg::set_idx_t'(i)});

    va = random_vpn();
    refill_entry(va, rand_data(1'b0));
    lookup(va);
    lookup({~va[ctlb_pkg::VPN_BITS-1:ctlb_pkg::SET_BITS], va[ctlb_pkg::SET_BITS-1:0]});

    // Five tags into four ways force one eviction
    s = ctlb_pkg::set_idx_t'($urandom);
    for (int i = 0; i < 5; i++)
    begin
      pool[i] = {ctlb_pkg::tag_t'(i * 7 + 1), s};
      refill_entry(pool[i], rand_data(1'b0));
      lookup(pool[$urandom % (i + 1)]);
      lookup(random_vpn());
    end
    for (int i = 0; i < 5; i++)
      lookup(pool[i]);

    csr_write(ctlb_pkg::CSR_PROC, 64'h12);
    csr_write(ctlb_pkg::CSR_MFLAGS, 64'(1) << ctlb_pkg::MFLAGS_VM);
    va = {ctlb_pkg::tag_t'(46'h1234), ctlb_pkg::set_idx_t'(9)};
    vg = {ctlb_pkg::tag_t'(46'h5678), ctlb_pkg::set_idx_t'(9)};
    refill_entry(va, rand_data(1'b0));
    refill_entry(vg, rand_data(1'b1));
    lookup(va);
    lookup(vg);
    csr_write(ctlb_pkg::CSR_PROC, 64'h34);
    lookup(va);
    lookup(vg);
    csr_write(ctlb_pkg::CSR_MFLAGS, '0);
    lookup(va);
    lookup(vg);
    csr_write(ctlb_pkg::CSR_PROC, 64'h12);
    csr_write(ctlb_pkg::CSR_MFLAGS, 64'(1) << ctlb_pkg::MFLAGS_VM);
    lookup(va);
    lookup(vg);

    s = ctlb_pkg::set_idx_t'(20);
    for (int i = 0; i < 4; i++)
    begin
      pool[i] = {ctlb_pkg::tag_t'(100 + i), s};
      refill_entry(pool[i], rand_data(1'b0));
    end
    invalidate_entry(pool[2]);
    for (int i = 0; i < 4; i++)
      lookup(pool[i]);

    va = {ctlb_pkg::tag_t'(999), s};
    drive_op(1'b0, 1'b1, 1'b0, 1'b1, va, rand_data(1'b0));
    drive_op(1'b0, 1'b0, 1'b1, 1'b1, pool[0], '0);
    drive_op(1'b1, 1'b0, 1'b0, 1'b1, pool[1], '0);
    lookup(va);
    lookup(pool[0]);

    // Small tag pool in four sets; only tag 5 is global so one vpn never sits in two ways
    for (int i = 0; i < 300; i++)
    begin
      va = {ctlb_pkg::tag_t'($urandom % 6), ctlb_pkg::set_idx_t'($urandom % 4)};
      case ($urandom % 8)
        0, 1: drive_op(1'($urandom % 2), 1'b1, 1'($urandom % 2), ($urandom % 5) == 0, va,
                       rand_data(va[ctlb_pkg::VPN_BITS-1:ctlb_pkg::SET_BITS] == 5));
        2: drive_op(1'b0, 1'b0, 1'b1, ($urandom % 5) == 0, va, '0);
        3: csr_write(ctlb_pkg::CSR_PROC, ctlb_pkg::csr_data_t'($urandom % 3));
        4: csr_write(ctlb_pkg::CSR_MFLAGS, ctlb_pkg::csr_data_t'($urandom));
        default: drive_op(1'b1, 1'b0, 1'b0, ($urandom % 5) == 0, va, '0);
      endcase
    end
    drive_op(1'b0, 1'b0, 1'b0, 1'b0, va, '0);
    drive_op(1'b0, 1'b0, 1'b0, 1'b0, va, '0);
    @(posedge clk);

    if (n_hits == 0)
    begin
      err_other++;
      $display("No lookup ever hit, so the stimulus never exercised a stored entry");
    end
    $display("Checks %0d, hits %0d, hit errors %0d, data errors %0d, other errors %0d",
             n_checks, n_hits, err_hit, err_data, err_other);
    if (err_hit + err_data + err_other == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: files.f
source/ctlb_pkg.sv
source/ctlb_ram.sv
source/ctlb_way.sv
source/ctlb_lru_update.sv
source/ctlb_csr_watch.sv
source/ctlb.sv
test/ctlb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the TLB testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f files.f --top-module ctlb_tb \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vctlb_tb > sim.log 2>&1
cat sim.log
grep -qx "Everything OK" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
exit 0
